// File: Makefile
# Verilator build and run for the frog-crossing game core

SIM      := verilator
TOP      := frogger_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert --Mdir $(OBJ_DIR)
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/frogger_assert.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the game core top level, bound in from the
// testbench. Covers handshake, score and row limits and the life count.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frogger_assert (
	input logic                 CLOCK_50,
	input logic                 resetN,
	input logic                 restart,
	input logic                 move_ready,
	input logic                 game_over,
	input logic                 collision,
	input game_pkg::score_t     score,
	input game_pkg::lives_t     lives_lost,
	input screen_pkg::coord_y_t frog_y
);
	int fail_count = 0;	// Read by the testbench at the end

	ready_only_in_play: assert property (@(posedge CLOCK_50) disable iff (!resetN)
		move_ready |-> !game_over)
	else
	begin
		$error("move_ready high while the game is over");
		fail_count = fail_count + 1;
	end

	score_in_range: assert property (@(posedge CLOCK_50) disable iff (!resetN)
		score <= 4'd12)
	else
	begin
		$error("score above the winning score");
		fail_count = fail_count + 1;
	end

	row_in_range: assert property (@(posedge CLOCK_50) disable iff (!resetN)
		frog_y <= 7'd104)
	else
	begin
		$error("frog below its lowest row");
		fail_count = fail_count + 1;
	end

	// A hit in play costs exactly one life at the next edge
	hit_costs_life: assert property (@(posedge CLOCK_50) disable iff (!resetN)
		(!game_over && collision && !restart) |=> (lives_lost == $past(lives_lost) + 2'd1))
	else
	begin
		$error("collision did not add one lost life");
		fail_count = fail_count + 1;
	end

endmodule

`default_nettype wire

// File: dv/frogger_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the frog-crossing game core. Drives random moves and rare
// restarts on the falling clock edge, runs a cycle-accurate game model
// and compares every output after each rising edge.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frogger_tb;
	import screen_pkg::*;
	import game_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_CYCLES   = 20000;
	localparam int FRAME_LEN    = 32;	// Short frames for simulation
	localparam int WATCHDOG_NS  = 2 * (NUM_CYCLES + RESET_CYCLES) * CLK_PERIOD;

	logic      CLOCK_50;
	logic      resetN;
	logic      restart;
	logic      move_valid;
	move_dir_t move_dir;
	logic      move_ready;
	coord_x_t  frog_x;
	coord_y_t  frog_y;
	score_t    score;
	lives_t    lives_lost;
	logic      game_over;
	logic      collision;

	coord_x_t    m_x;	// Model frog column
	coord_y_t    m_y;
	score_t      m_score;
	lives_t      m_lives;
	game_state_t m_state;
	int          m_lane [LANE_COUNT];
	int          m_frame;
	logic        move_taken;	// Offer accepted at the last edge
	int unsigned lcg_state;

	frogger_top #(
		.FRAME_CYCLES (FRAME_LEN)
	) dut_i (
		.CLOCK_50   (CLOCK_50),
		.resetN     (resetN),
		.restart    (restart),
		.move_valid (move_valid),
		.move_dir   (move_dir),
		.move_ready (move_ready),
		.frog_x     (frog_x),
		.frog_y     (frog_y),
		.score      (score),
		.lives_lost (lives_lost),
		.game_over  (game_over),
		.collision  (collision)
	);

	bind frogger_top frogger_assert assert_i (
		.CLOCK_50   (CLOCK_50),
		.resetN     (resetN),
		.restart    (restart),
		.move_ready (move_ready),
		.game_over  (game_over),
		.collision  (collision),
		.score      (score),
		.lives_lost (lives_lost),
		.frog_y     (frog_y)
	);

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;	// Low bits repeat too quickly
	endfunction

	// Rows per frame from the score table
	function automatic int lane_rate(input int lane, input score_t s);
		int rate;
		case (lane)
			0: rate = (s < 4'd7) ? 1 : 2;
			1: rate = (s < 4'd5) ? 1 : 2;
			2: rate = (s < 4'd10) ? 1 : 2;
			default: rate = (s < 4'd3) ? 1 : (s < 4'd10) ? 2 : (s < 4'd11) ? 4 : 3;
		endcase
		return rate;
	endfunction

	// Frog box against every car box on the wrapping screen
	function automatic logic car_overlap(input int x, input int y);
		int   lx;
		int   top;
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < CAR_COUNT; i++)
		begin
			lx  = int'(LANE_X[CAR_LANE[i]]);
			top = (m_lane[CAR_LANE[i]] + CAR_OFFSET[i]) % SCREEN_HEIGHT;
			if ((x < lx + 16) && (x + 16 > lx) &&
				(((y - top + 2 * SCREEN_HEIGHT) % SCREEN_HEIGHT < 16) ||
				 ((top - y + 2 * SCREEN_HEIGHT) % SCREEN_HEIGHT < 16)))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// True when one step in dir lands clear of every car
	function automatic logic step_is_clear(input move_dir_t dir);
		int x;
		int y;
		x = int'(m_x);
		y = int'(m_y);
		case (dir)
			UP:      y = y - 4;
			DOWN:    y = y + 4;
			LEFT:    x = x - 4;
			default: x = x + 4;
		endcase
		return !car_overlap(x, y);
	endfunction

	function automatic move_dir_t pick_dir(input int unsigned r);
		move_dir_t dir;
		if (r % 16 < 2)
			dir = LEFT;
		else if (r % 16 < 12)
			dir = RIGHT;
		else if (r % 2 == 0)
			dir = UP;
		else
			dir = DOWN;
		// Steer around cars most of the time so that games can also be won
		if ((r / 16) % 8 != 0 && !step_is_clear(dir))
		begin
			if (step_is_clear(RIGHT))
				dir = RIGHT;
			else if (step_is_clear(UP))
				dir = UP;
			else if (step_is_clear(DOWN))
				dir = DOWN;
			else
				dir = LEFT;
		end
		return dir;
	endfunction

	task automatic send_home();
		m_x = 8'd0;
		m_y = 7'd53;
	endtask

	task automatic model_clear();
		send_home();
		m_score = '0;
		m_lives = '0;
		m_state = PLAY;
		m_frame = 0;
		for (int i = 0; i < LANE_COUNT; i++)
			m_lane[i] = 0;
	endtask

	task automatic apply_move();
		case (move_dir)
			UP:
				if (m_y >= 7'd4)
					m_y = m_y - 7'd4;
			DOWN:
				if (int'(m_y) + 4 <= 104)
					m_y = m_y + 7'd4;
			LEFT:
				if (m_x >= 8'd4)
					m_x = m_x - 8'd4;
			default:
			begin
				if (int'(m_x) + 4 >= 144)
				begin
					m_score = m_score + 4'd1;	// Crossing
					send_home();
					if (m_score == 4'd12)
						m_state = OVER;
				end
				else
					m_x = m_x + 8'd4;
			end
		endcase
	endtask

	// One rising edge of the model from the state and inputs before it
	task automatic model_update();
		logic hit;
		logic take;
		hit        = car_overlap(int'(m_x), int'(m_y));
		take       = move_valid && (m_state == PLAY) && !hit && !restart;
		move_taken = take;
		if (restart)
			model_clear();
		else
		begin
			if (m_frame == FRAME_LEN - 1)
			begin
				m_frame = 0;
				if (m_state == PLAY)
				begin
					for (int i = 0; i < LANE_COUNT; i++)
						m_lane[i] = (m_lane[i] + lane_rate(i, m_score)) % SCREEN_HEIGHT;
				end
			end
			else
				m_frame++;
			if ((m_state == PLAY) && hit)
			begin
				m_lives = m_lives + 2'd1;
				send_home();
				if (m_lives == 2'd3)
					m_state = OVER;
			end
			else if (take)
				apply_move();
		end
	endtask

	task automatic drive_inputs();
		int unsigned r;
		r       = next_rand();
		restart = 1'b0;
		if ((m_state == OVER && r % 8 == 0) || r % 3000 == 1)
		begin
			restart    = 1'b1;
			move_valid = 1'b0;	// Never offered with a restart
		end
		else if (!move_valid || move_taken)
		begin
			move_valid = (r % 4) != 0;
			move_dir   = pick_dir(next_rand());
		end
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR %s: DUT 0x%0h, expected 0x%0h", name, got, exp);
		$display("tests failed");
		$fatal(1, "Output mismatch");
	endtask

	task automatic compare_x(input string name, input coord_x_t got, input coord_x_t exp);
		if (got !== exp)
			mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_y(input string name, input coord_y_t got, input coord_y_t exp);
		if (got !== exp)
			mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_score(input string name, input score_t got, input score_t exp);
		if (got !== exp)
			mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_lives(input string name, input lives_t got, input lives_t exp);
		if (got !== exp)
			mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_outputs();
		logic hit_exp;
		hit_exp = car_overlap(int'(m_x), int'(m_y));
		compare_x("frog_x", frog_x, m_x);
		compare_y("frog_y", frog_y, m_y);
		compare_y("lane0_y", dut_i.lane0_y, coord_y_t'(m_lane[0]));
		compare_y("lane1_y", dut_i.lane1_y, coord_y_t'(m_lane[1]));
		compare_y("lane2_y", dut_i.lane2_y, coord_y_t'(m_lane[2]));
		compare_y("lane3_y", dut_i.lane3_y, coord_y_t'(m_lane[3]));
		compare_score("score", score, m_score);
		compare_lives("lives_lost", lives_lost, m_lives);
		compare_bit("game_over", game_over, m_state == OVER);
		compare_bit("collision", collision, hit_exp);
		compare_bit("move_ready", move_ready, (m_state == PLAY) && !hit_exp && !restart);
	endtask

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the test loop did not finish within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$fatal(1, "Timeout");
	end

	initial
	begin
		resetN     = 1'b0;
		restart    = 1'b0;
		move_valid = 1'b0;
		move_dir   = UP;
		move_taken = 1'b0;
		lcg_state  = 35;
		model_clear();
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		check_outputs();	// Reset values
		resetN = 1'b1;
		drive_inputs();
		repeat (NUM_CYCLES)
		begin
			@(posedge CLOCK_50);
			model_update();
			@(negedge CLOCK_50);
			check_outputs();
			drive_inputs();
		end
		if (dut_i.assert_i.fail_count == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("Bound assertions failed %0d times", dut_i.assert_i.fail_count);
			$display("tests failed");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

`default_nettype wire

// File: logic/frog_game_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Game state machine. Keeps the frog position, score and lives lost,
// accepts move commands over a valid/ready handshake and ends the game
// on too many hits or enough crossings. Restart clears everything.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frog_game_fsm (
	input  logic                 CLOCK_50,
	input  logic                 resetN,
	input  logic                 restart,
	input  logic                 move_valid,
	input  game_pkg::move_dir_t  move_dir,
	input  logic                 collision,
	output logic                 move_ready,
	output screen_pkg::coord_x_t frog_x,
	output screen_pkg::coord_y_t frog_y,
	output game_pkg::score_t     score,
	output game_pkg::lives_t     lives_lost,
	output logic                 game_over
);
	import screen_pkg::*;
	import game_pkg::*;

	game_state_t state;
	game_state_t state_next;
	coord_x_t    x_next;
	coord_y_t    y_next;
	score_t      score_next;
	lives_t      lives_next;
	logic        move_accept;
	coord_x_t    x_right;	// Column after a right step

	// A hit or a restart this cycle takes priority over any move
	assign move_ready  = (state == PLAY) && !collision && !restart;
	assign move_accept = move_valid && move_ready;
	assign game_over   = (state == OVER);
	assign x_right     = frog_x + coord_x_t'(STEP);

	always_comb
	begin
		state_next = state;
		x_next     = frog_x;
		y_next     = frog_y;
		score_next = score;
		lives_next = lives_lost;

		if (restart)
		begin
			state_next = PLAY;
			x_next     = FROG_HOME_X;
			y_next     = FROG_HOME_Y;
			score_next = '0;
			lives_next = '0;
		end
		else if ((state == PLAY) && collision)
		begin
			lives_next = lives_lost + 2'd1;
			x_next     = FROG_HOME_X;	// Back to start after a hit
			y_next     = FROG_HOME_Y;
			if (lives_next == MAX_LIVES_LOST)
				state_next = OVER;
		end
		else if (move_accept)
		begin
			case (move_dir)
				UP:
				begin
					if (frog_y >= coord_y_t'(STEP))
						y_next = frog_y - coord_y_t'(STEP);
				end
				DOWN:
				begin
					if (frog_y + coord_y_t'(STEP) <= FROG_MAX_Y)
						y_next = frog_y + coord_y_t'(STEP);
				end
				LEFT:
				begin
					if (frog_x >= coord_x_t'(STEP))
						x_next = frog_x - coord_x_t'(STEP);
				end
				default:
				begin
					if (x_right >= GOAL_X)
					begin
						score_next = score + 4'd1;	// Made it across
						x_next     = FROG_HOME_X;
						y_next     = FROG_HOME_Y;
						if (score_next == WIN_SCORE)
							state_next = OVER;
					end
					else
						x_next = x_right;
				end
			endcase
		end
	end

	always_ff @(posedge CLOCK_50 or negedge resetN)
	begin
		if (!resetN)
		begin
			state      <= PLAY;
			frog_x     <= FROG_HOME_X;
			frog_y     <= FROG_HOME_Y;
			score      <= '0;
			lives_lost <= '0;
		end
		else
		begin
			state      <= state_next;
			frog_x     <= x_next;
			frog_y     <= y_next;
			score      <= score_next;
			lives_lost <= lives_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/frogger_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the frog-crossing game core. Connects the game FSM, the
// lane mover and the hit test. FRAME_CYCLES sets the frame length;
// short values suit simulation.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frogger_top #(
	parameter int unsigned FRAME_CYCLES = game_pkg::FRAME_CYCLES_DEFAULT
) (
	input  logic                 CLOCK_50,
	input  logic                 resetN,
	input  logic                 restart,
	input  logic                 move_valid,
	input  game_pkg::move_dir_t  move_dir,
	output logic                 move_ready,
	output screen_pkg::coord_x_t frog_x,
	output screen_pkg::coord_y_t frog_y,
	output game_pkg::score_t     score,
	output game_pkg::lives_t     lives_lost,
	output logic                 game_over,
	output logic                 collision
);
	import screen_pkg::*;

	coord_y_t lane0_y;	// Lane rows from the mover
	coord_y_t lane1_y;
	coord_y_t lane2_y;
	coord_y_t lane3_y;

	frog_game_fsm fsm_i (
		.CLOCK_50   (CLOCK_50),
		.resetN     (resetN),
		.restart    (restart),
		.move_valid (move_valid),
		.move_dir   (move_dir),
		.collision  (collision),
		.move_ready (move_ready),
		.frog_x     (frog_x),
		.frog_y     (frog_y),
		.score      (score),
		.lives_lost (lives_lost),
		.game_over  (game_over)
	);

	lane_motion #(
		.FRAME_CYCLES (FRAME_CYCLES)
	) lanes_i (
		.CLOCK_50  (CLOCK_50),
		.resetN    (resetN),
		.restart   (restart),
		.score     (score),
		.game_over (game_over),
		.lane0_y   (lane0_y),
		.lane1_y   (lane1_y),
		.lane2_y   (lane2_y),
		.lane3_y   (lane3_y)
	);

	hit_detector hit_i (
		.frog_x    (frog_x),
		.frog_y    (frog_y),
		.lane0_y   (lane0_y),
		.lane1_y   (lane1_y),
		.lane2_y   (lane2_y),
		.lane3_y   (lane3_y),
		.collision (collision)
	);

endmodule

`default_nettype wire

// File: logic/game_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Game rules for the frog-crossing core: score and lives types, move
// directions, game states, end-of-game limits, frame length and the
// score-dependent lane speed table.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package game_pkg;

	typedef logic [3:0]  score_t;
	typedef logic [1:0]  lives_t;	// Lives lost so far
	typedef logic [2:0]  speed_t;	// Rows per frame
	typedef logic [19:0] frame_count_t;

	typedef enum logic [1:0] {
		UP,
		DOWN,
		LEFT,
		RIGHT
	} move_dir_t;

	typedef enum logic {
		PLAY,
		OVER
	} game_state_t;

	localparam score_t WIN_SCORE      = 4'd12;
	localparam lives_t MAX_LIVES_LOST = 2'd3;

	localparam int unsigned FRAME_CYCLES_DEFAULT = 1_000_000;	// 50 frames per second

	// Lanes speed up at different scores; lane 3 peaks at score 10
	function automatic speed_t lane_speed(input int lane, input score_t score);
		speed_t speed;
		case (lane)
			0: speed = (score < 4'd7) ? 3'd1 : 3'd2;
			1: speed = (score < 4'd5) ? 3'd1 : 3'd2;
			2: speed = (score < 4'd10) ? 3'd1 : 3'd2;
			default:
			begin
				if (score < 4'd3)
					speed = 3'd1;
				else if (score < 4'd10)
					speed = 3'd2;
				else if (score < 4'd11)
					speed = 3'd4;
				else
					speed = 3'd3;
			end
		endcase
		return speed;
	endfunction

endpackage

`default_nettype wire

// File: logic/hit_detector.sv
////////////////////////////////////////////////////////////////////////////
// Combinational hit test of the frog against all seven cars. Rows wrap
// at the screen bottom, so a car split across the edge still hits.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module hit_detector (
	input  screen_pkg::coord_x_t frog_x,
	input  screen_pkg::coord_y_t frog_y,
	input  screen_pkg::coord_y_t lane0_y,
	input  screen_pkg::coord_y_t lane1_y,
	input  screen_pkg::coord_y_t lane2_y,
	input  screen_pkg::coord_y_t lane3_y,
	output logic                 collision
);
	import screen_pkg::*;

	coord_y_t             lane_y [LANE_COUNT];
	logic [CAR_COUNT-1:0] car_hit;

	// Top row of a car, modulo the screen height
	function automatic coord_y_t car_top(input coord_y_t lane_row, input int offset);
		int row;
		row = int'(lane_row) + offset;
		if (row >= SCREEN_HEIGHT)
			row = row - SCREEN_HEIGHT;
		return coord_y_t'(row);
	endfunction

	// Distance from b down to a on the wrapping screen
	function automatic int row_gap(input coord_y_t a, input coord_y_t b);
		int gap;
		gap = int'(a) - int'(b);
		if (gap < 0)
			gap = gap + SCREEN_HEIGHT;
		return gap;
	endfunction

	assign lane_y[0] = lane0_y;
	assign lane_y[1] = lane1_y;
	assign lane_y[2] = lane2_y;
	assign lane_y[3] = lane3_y;

	always_comb
	begin
		for (int i = 0; i < CAR_COUNT; i++)
		begin
			car_hit[i] =
				(int'(frog_x) < int'(LANE_X[CAR_LANE[i]]) + SPRITE_SIZE) &&
				(int'(frog_x) + SPRITE_SIZE > int'(LANE_X[CAR_LANE[i]])) &&
				((row_gap(frog_y, car_top(lane_y[CAR_LANE[i]], CAR_OFFSET[i])) < SPRITE_SIZE) ||
				 (row_gap(car_top(lane_y[CAR_LANE[i]], CAR_OFFSET[i]), frog_y) < SPRITE_SIZE));
		end
	end

	assign collision = |car_hit;	// Any car touching the frog

endmodule

`default_nettype wire

// File: logic/lane_motion.sv
////////////////////////////////////////////////////////////////////////////
// Lane mover. A frame timer of FRAME_CYCLES clocks steps all four lanes
// down the screen once per frame at a speed set by the score, wrapping
// at the bottom. Lanes hold while the game is over.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lane_motion #(
	parameter int unsigned FRAME_CYCLES = game_pkg::FRAME_CYCLES_DEFAULT
) (
	input  logic                 CLOCK_50,
	input  logic                 resetN,
	input  logic                 restart,
	input  game_pkg::score_t     score,
	input  logic                 game_over,
	output screen_pkg::coord_y_t lane0_y,
	output screen_pkg::coord_y_t lane1_y,
	output screen_pkg::coord_y_t lane2_y,
	output screen_pkg::coord_y_t lane3_y
);
	import screen_pkg::*;
	import game_pkg::*;

	frame_count_t frame_count;
	logic         frame_end;
	coord_y_t     lane_y   [LANE_COUNT];
	coord_y_t     lane_adv [LANE_COUNT];	// Position after this frame

	// Row plus speed, wrapped back to the top of the screen
	function automatic coord_y_t wrap_row(input coord_y_t row, input speed_t speed);
		logic [7:0] sum;
		sum = {1'b0, row} + {5'd0, speed};
		if (sum >= 8'(SCREEN_HEIGHT))
			sum = sum - 8'(SCREEN_HEIGHT);
		return coord_y_t'(sum);
	endfunction

	assign frame_end = (frame_count == frame_count_t'(FRAME_CYCLES - 1));

	always_ff @(posedge CLOCK_50 or negedge resetN)
	begin
		if (!resetN)
			frame_count <= '0;
		else if (restart || frame_end)
			frame_count <= '0;
		else
			frame_count <= frame_count + 20'd1;
	end

	always_comb
	begin
		for (int i = 0; i < LANE_COUNT; i++)
			lane_adv[i] = wrap_row(lane_y[i], lane_speed(i, score));
	end

	always_ff @(posedge CLOCK_50 or negedge resetN)
	begin
		if (!resetN)
		begin
			for (int i = 0; i < LANE_COUNT; i++)
				lane_y[i] <= '0;
		end
		else if (restart)
		begin
			for (int i = 0; i < LANE_COUNT; i++)
				lane_y[i] <= '0;
		end
		else if (frame_end && !game_over)
			lane_y <= lane_adv;
	end

	assign lane0_y = lane_y[0];
	assign lane1_y = lane_y[1];
	assign lane2_y = lane_y[2];
	assign lane3_y = lane_y[3];

endmodule

`default_nettype wire

// File: logic/screen_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Screen geometry for the frog-crossing game core. Holds the coordinate
// types, sprite size, frog home and limits, and where the cars sit in
// each lane. Import inside a module body where these are needed.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package screen_pkg;

	typedef logic [7:0] coord_x_t;	// Column, 0 to 159
	typedef logic [6:0] coord_y_t;	// Row, 0 to 119

	localparam int SCREEN_WIDTH  = 160;
	localparam int SCREEN_HEIGHT = 120;
	localparam int SPRITE_SIZE   = 16;	// Frog and car edge
	localparam int STEP          = 4;	// One frog move

	localparam coord_x_t FROG_HOME_X = 8'd0;
	localparam coord_y_t FROG_HOME_Y = 7'd53;

	// Right move landing here or beyond counts as a crossing
	localparam coord_x_t GOAL_X     = coord_x_t'(SCREEN_WIDTH - SPRITE_SIZE);
	localparam coord_y_t FROG_MAX_Y = coord_y_t'(SCREEN_HEIGHT - SPRITE_SIZE);

	localparam int LANE_COUNT = 4;

	// Left column of each lane
	localparam coord_x_t LANE_X [LANE_COUNT] = '{8'd18, 8'd34, 8'd90, 8'd108};

	localparam int CAR_COUNT = 7;

	// Lane of each car and its row offset from the lane position
	localparam int CAR_LANE   [CAR_COUNT] = '{0, 1, 1, 2, 3, 3, 3};
	localparam int CAR_OFFSET [CAR_COUNT] = '{0, 0, 40, 60, 0, 18, 36};

endpackage

`default_nettype wire

// File: src.f
logic/screen_pkg.sv
logic/game_pkg.sv
logic/frog_game_fsm.sv
logic/lane_motion.sv
logic/hit_detector.sv
logic/frogger_top.sv
dv/frogger_assert.sv
dv/frogger_tb.sv
